// File: common/frontend_config.svh
`ifndef frontend_config_svh
`define frontend_config_svh

// number of instruction pairs held by the fetch buffer, must be a power of two
`define fe_fb_depth 8

// andi r0,r0,0 is the canonical LoongArch NOP
`define fe_inst_nop 32'h0340_0000

// pc carried by a bubble, matches the core reset vector
`define fe_pc_reset 32'h1c00_0000

`endif

// File: common/frontend_pkg.sv
package frontend_pkg;

    // instruction classes recognised by the decode stage
    typedef enum logic [2:0] {
        op_nop     = 3'd0,
        op_add     = 3'd1,
        op_addi    = 3'd2,
        op_load    = 3'd3,
        op_store   = 3'd4,
        op_beq     = 3'd5,
        op_invalid = 3'd6
    } op_e;

    // one fetched pair as it leaves the fetch unit, pc is the address of inst0
    typedef struct packed {
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] pc;
        logic        excp_flag;
        logic [6:0]  ecode;
    } fetch_entry_t;

    // one decoded instruction
    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
    } decoded_t;

    // everything the decode stage hands to the next stage
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc_add;
        logic        excp_flag;
        logic [6:0]  ecode;
        decoded_t    dec0;
        decoded_t    dec1;
    } id_bundle_t;

endpackage

// File: fetch_buffer/fetch_buffer.sv
`timescale 1ns/1ns
`include "frontend_config.svh"

module fetch_buffer (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       flush,
    input  logic                       fetch_valid,
    input  frontend_pkg::fetch_entry_t fetch_entry,
    output logic                       fetch_buf_full,
    input  logic                       fifo_allowin,
    output logic                       fifo_readygo,
    output frontend_pkg::fetch_entry_t head_entry
);

    localparam int depth = `fe_fb_depth;
    localparam int ptr_w = $clog2(depth);

    frontend_pkg::fetch_entry_t mem [depth];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w:0]   count;
    logic             empty;
    logic             push;
    logic             pop;

    assign empty          = (count == '0);
    assign fetch_buf_full = (count == (ptr_w + 1)'(depth));

    // the decode side sees the buffer as valid whenever it holds a pair
    assign fifo_readygo = !empty;
    assign head_entry   = mem[rd_ptr];

    // a flush kills both sides of the queue in the same cycle
    assign push = fetch_valid && !fetch_buf_full && !flush;
    assign pop  = fifo_readygo && fifo_allowin && !flush;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the count unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage only, the pointers decide what is live
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fetch_entry;
        end
    end

endmodule

// File: rtl/fifo_id_reg.sv
`timescale 1ns/1ns
`include "frontend_config.svh"

module fifo_id_reg (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       flush,
    input  logic                       stall,
    input  logic                       id_allowin,
    output logic                       id_readygo,
    output logic                       fifo_allowin,
    input  logic                       fifo_readygo,
    input  frontend_pkg::fetch_entry_t head_entry,
    output frontend_pkg::fetch_entry_t stage_entry,
    output logic [31:0]                stage_pc_add
);

    localparam frontend_pkg::fetch_entry_t bubble = '{
        inst0:     `fe_inst_nop,
        inst1:     `fe_inst_nop,
        pc:        `fe_pc_reset,
        excp_flag: 1'b0,
        ecode:     7'd0
    };

    logic valid;
    logic advance;
    logic take_head;

    // stall also holds the buffer so no pair is popped into a frozen stage
    assign advance      = id_allowin && !stall;
    assign fifo_allowin = advance;
    assign take_head    = advance && fifo_readygo;
    assign id_readygo   = valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (advance) begin
            // an empty buffer leaves a bubble behind
            valid <= fifo_readygo;
        end
    end

    always_ff @(posedge clk) begin
        if (flush || (advance && !fifo_readygo)) begin
            stage_entry  <= bubble;
            stage_pc_add <= `fe_pc_reset + 32'd4;
        end else if (take_head) begin
            stage_entry  <= head_entry;
            stage_pc_add <= head_entry.pc + 32'd4;
        end
    end

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/1ns
`include "frontend_config.svh"

module inst_decoder (
    input  logic [31:0]            inst,
    output frontend_pkg::decoded_t dec
);

    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [31:0] imm_si12;
    logic [31:0] imm_offs16;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // si12 for addi and the memory ops
    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    // branch offset counts words, so it is shifted into a byte offset
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};

    always_comb begin
        dec = '{
            op:  frontend_pkg::op_invalid,
            rd:  5'd0,
            rj:  5'd0,
            rk:  5'd0,
            imm: 32'd0
        };
        if (inst == `fe_inst_nop) begin
            dec.op = frontend_pkg::op_nop;
        end else begin
            // opcode fields differ in width, so the shorter ones wildcard the tail
            casez (inst[31:15])
                17'h0_0020: begin
                    dec.op = frontend_pkg::op_add;
                    dec.rd = rd;
                    dec.rj = rj;
                    dec.rk = rk;
                end
                {10'h00a, 7'b???????}: begin
                    dec.op  = frontend_pkg::op_addi;
                    dec.rd  = rd;
                    dec.rj  = rj;
                    dec.imm = imm_si12;
                end
                {10'h0a2, 7'b???????}: begin
                    dec.op  = frontend_pkg::op_load;
                    dec.rd  = rd;
                    dec.rj  = rj;
                    dec.imm = imm_si12;
                end
                {10'h0a6, 7'b???????}: begin
                    dec.op  = frontend_pkg::op_store;
                    dec.rd  = rd;
                    dec.rj  = rj;
                    dec.imm = imm_si12;
                end
                {6'h16, 11'b???????????}: begin
                    dec.op  = frontend_pkg::op_beq;
                    dec.rd  = rd;
                    dec.rj  = rj;
                    dec.imm = imm_offs16;
                end
                default: begin
                    dec.op = frontend_pkg::op_invalid;
                end
            endcase
        end
    end

endmodule

// File: rtl/frontend_top.sv
`timescale 1ns/1ns

module frontend_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       flush,
    input  logic                       stall,
    input  logic                       fetch_valid,
    input  frontend_pkg::fetch_entry_t fetch_entry,
    output logic                       fetch_buf_full,
    input  logic                       id_allowin,
    output logic                       id_readygo,
    output frontend_pkg::id_bundle_t   id_bundle
);

    logic                       fifo_allowin;
    logic                       fifo_readygo;
    frontend_pkg::fetch_entry_t head_entry;
    frontend_pkg::fetch_entry_t stage_entry;
    logic [31:0]                stage_pc_add;
    frontend_pkg::decoded_t     dec0;
    frontend_pkg::decoded_t     dec1;

    fetch_buffer fetch_buffer_inst (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .fetch_valid    (fetch_valid),
        .fetch_entry    (fetch_entry),
        .fetch_buf_full (fetch_buf_full),
        .fifo_allowin   (fifo_allowin),
        .fifo_readygo   (fifo_readygo),
        .head_entry     (head_entry)
    );

    fifo_id_reg fifo_id_reg_inst (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .stall        (stall),
        .id_allowin   (id_allowin),
        .id_readygo   (id_readygo),
        .fifo_allowin (fifo_allowin),
        .fifo_readygo (fifo_readygo),
        .head_entry   (head_entry),
        .stage_entry  (stage_entry),
        .stage_pc_add (stage_pc_add)
    );

    // one decoder per issue slot
    inst_decoder dec0_inst (
        .inst (stage_entry.inst0),
        .dec  (dec0)
    );

    inst_decoder dec1_inst (
        .inst (stage_entry.inst1),
        .dec  (dec1)
    );

    assign id_bundle = '{
        pc:        stage_entry.pc,
        pc_add:    stage_pc_add,
        excp_flag: stage_entry.excp_flag,
        ecode:     stage_entry.ecode,
        dec0:      dec0,
        dec1:      dec1
    };

endmodule

// File: test/frontend_tb.sv
`timescale 1ns/1ns
`include "frontend_config.svh"

module frontend_tb;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    localparam int num_cycles   = 4000;
    localparam int depth        = `fe_fb_depth;
    // run length plus reset plus a small margin for the tail of the run
    localparam int timeout_ns   = (num_cycles + reset_cycles + 10) * clk_period + 200;

    logic                       clk = 1'b0;
    logic                       rstn;
    logic                       flush;
    logic                       stall;
    logic                       fetch_valid;
    frontend_pkg::fetch_entry_t fetch_entry;
    logic                       fetch_buf_full;
    logic                       id_allowin;
    logic                       id_readygo;
    frontend_pkg::id_bundle_t   id_bundle;

    // reference model state
    frontend_pkg::fetch_entry_t fb_q[$];
    frontend_pkg::fetch_entry_t stg_entry;
    logic                       stg_valid;
    logic [31:0]                pc_counter;
    int                         dut_consumed;
    logic [31:0]                last_pc;
    logic                       have_last;
    logic [31:0]                rng_state;

    frontend_top frontend_top_inst (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .stall          (stall),
        .fetch_valid    (fetch_valid),
        .fetch_entry    (fetch_entry),
        .fetch_buf_full (fetch_buf_full),
        .id_allowin     (id_allowin),
        .id_readygo     (id_readygo),
        .id_bundle      (id_bundle)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // one of the six known encodings or a raw random word
    function automatic logic [31:0] gen_inst();
        logic [31:0] sel;
        logic [31:0] r;
        logic [31:0] inst;
        sel = next_rand() % 32'd7;
        r = next_rand();
        case (sel)
            32'd0:   inst = `fe_inst_nop;
            32'd1:   inst = {17'h0_0020, r[14:0]};
            32'd2:   inst = {10'h00a, r[21:0]};
            32'd3:   inst = {10'h0a2, r[21:0]};
            32'd4:   inst = {10'h0a6, r[21:0]};
            32'd5:   inst = {6'h16, r[25:0]};
            default: inst = r;
        endcase
        return inst;
    endfunction

    function automatic frontend_pkg::decoded_t model_decode(input logic [31:0] inst);
        frontend_pkg::decoded_t d;
        d.op  = frontend_pkg::op_invalid;
        d.rd  = 5'd0;
        d.rj  = 5'd0;
        d.rk  = 5'd0;
        d.imm = 32'd0;
        if (inst == `fe_inst_nop) begin
            d.op = frontend_pkg::op_nop;
        end else if (inst[31:15] == 17'h0_0020) begin
            d.op = frontend_pkg::op_add;
            d.rd = inst[4:0];
            d.rj = inst[9:5];
            d.rk = inst[14:10];
        end else if (inst[31:22] == 10'h00a || inst[31:22] == 10'h0a2 ||
                     inst[31:22] == 10'h0a6) begin
            if (inst[31:22] == 10'h00a) begin
                d.op = frontend_pkg::op_addi;
            end else if (inst[31:22] == 10'h0a2) begin
                d.op = frontend_pkg::op_load;
            end else begin
                d.op = frontend_pkg::op_store;
            end
            d.rd  = inst[4:0];
            d.rj  = inst[9:5];
            d.imm = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:26] == 6'h16) begin
            d.op  = frontend_pkg::op_beq;
            d.rd  = inst[4:0];
            d.rj  = inst[9:5];
            d.imm = {{14{inst[25]}}, inst[25:10], 2'b00};
        end
        return d;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    // applies one clock edge to the model using the inputs seen at that edge
    task automatic update_model();
        logic do_push;
        logic advance;
        if (flush) begin
            fb_q.delete();
            stg_valid = 1'b0;
        end else begin
            do_push = fetch_valid && (fb_q.size() < depth);
            advance = id_allowin && !stall;
            if (advance) begin
                // the head is taken before this edge's push lands
                if (fb_q.size() > 0) begin
                    stg_entry = fb_q.pop_front();
                    stg_valid = 1'b1;
                end else begin
                    stg_valid = 1'b0;
                end
            end
            if (do_push) begin
                fb_q.push_back(fetch_entry);
                pc_counter = pc_counter + 32'd8;
            end
        end
    endtask

    task automatic drive_inputs();
        frontend_pkg::fetch_entry_t e;
        logic [31:0] r;
        r = next_rand();
        e.inst0     = gen_inst();
        e.inst1     = gen_inst();
        e.pc        = pc_counter;
        e.excp_flag = r[0];
        e.ecode     = r[7:1];
        fetch_entry <= e;
        fetch_valid <= (fb_q.size() < depth) && ((next_rand() % 32'd3) != 32'd0);
        id_allowin  <= (next_rand() % 32'd4) != 32'd0;
        stall       <= (next_rand() % 32'd10) == 32'd0;
        flush       <= (next_rand() % 32'd50) == 32'd0;
    endtask

    task automatic check_outputs();
        frontend_pkg::decoded_t exp0;
        frontend_pkg::decoded_t exp1;
        check_value("id_readygo", 64'(id_readygo), 64'(stg_valid));
        check_value("fetch_buf_full", 64'(fetch_buf_full), 64'(fb_q.size() == depth));
        if (id_readygo) begin
            exp0 = model_decode(stg_entry.inst0);
            exp1 = model_decode(stg_entry.inst1);
            check_value("pc", 64'(id_bundle.pc), 64'(stg_entry.pc));
            check_value("pc_add", 64'(id_bundle.pc_add), 64'(stg_entry.pc + 32'd4));
            check_value("excp_flag", 64'(id_bundle.excp_flag), 64'(stg_entry.excp_flag));
            check_value("ecode", 64'(id_bundle.ecode), 64'(stg_entry.ecode));
            check_value("dec0", 64'(id_bundle.dec0), 64'(exp0));
            check_value("dec1", 64'(id_bundle.dec1), 64'(exp1));
            // a consume at the coming edge must follow push order
            if (id_allowin && !stall && !flush) begin
                if (have_last) begin
                    check_value("consume order", 64'(id_bundle.pc > last_pc), 64'd1);
                end
                last_pc   = id_bundle.pc;
                have_last = 1'b1;
                dut_consumed++;
            end
        end
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog timeout: the run did not finish within %0d ns", timeout_ns);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rng_state      = 32'd21;
        rstn           = 1'b0;
        flush          = 1'b0;
        stall          = 1'b0;
        fetch_valid    = 1'b0;
        fetch_entry    = '0;
        id_allowin     = 1'b0;
        stg_entry      = '0;
        stg_valid      = 1'b0;
        pc_counter     = `fe_pc_reset;
        dut_consumed   = 0;
        last_pc        = 32'd0;
        have_last      = 1'b0;

        repeat (reset_cycles) begin
            @(negedge clk);
            check_value("id_readygo in reset", 64'(id_readygo), 64'd0);
            check_value("fetch_buf_full in reset", 64'(fetch_buf_full), 64'd0);
        end
        @(posedge clk);
        rstn <= 1'b1;
        drive_inputs();

        for (int cycle = 0; cycle < num_cycles; cycle++) begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            update_model();
            drive_inputs();
        end

        @(negedge clk);
        check_outputs();
        check_value("any pair consumed", 64'(dut_consumed > 0), 64'd1);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/frontend_pkg.sv
fetch_buffer/fetch_buffer.sv
rtl/fifo_id_reg.sv
rtl/inst_decoder.sv
rtl/frontend_top.sv
test/frontend_tb.sv

// File: Makefile
# Verilator build for the instruction front-end testbench
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM_ARGS  ?=

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator exits non-zero on $$fatal, so make fails with it
run: compile
	./$(BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
